//--- led_blinky_pkg.sv
//----------------------------------------------------------
// Shared types and constants for the LED pattern peripheral
//----------------------------------------------------------

package led_blinky_pkg;

	//----------------------------------------------------------
	// Sizes and reset values
	//----------------------------------------------------------

	// Number of LEDs driven
	localparam int LED_W = 4;

	// Dwell timer width
	localparam int TIMER_W = 24;

	// Timer after reset, low byte is fixed at ff
	localparam logic [TIMER_W-1:0] TIMER_RESET = 24'h0003ff;

	// LFSR state after reset or a zero seed
	localparam logic [LED_W-1:0] LFSR_RESET = 4'h1;

	//----------------------------------------------------------
	// Host command link
	//----------------------------------------------------------

	// Command operations, unlisted codes do nothing
	typedef enum logic [2:0] {
		OP_CONTROL      = 3'd0,
		OP_STATIC       = 3'd1,
		OP_SHIFT_PRESET = 3'd2,
		OP_TIMER_MID    = 3'd3,
		OP_TIMER_HIGH   = 3'd4,
		OP_SEED         = 3'd5
	} cmd_op_e;

	typedef struct packed {
		cmd_op_e    op;
		logic [7:0] value;
	} cmd_t;

	//----------------------------------------------------------
	// Control register and status report
	//----------------------------------------------------------

	// LED modes, codes 7 to 15 give a blank pattern
	typedef enum logic [3:0] {
		MODE_OFF         = 4'd0,
		MODE_RANDOM      = 4'd1,
		MODE_SHIFT_LEFT  = 4'd2,
		MODE_SHIFT_RIGHT = 4'd3,
		MODE_COUNT_UP    = 4'd4,
		MODE_COUNT_DOWN  = 4'd5,
		MODE_STATIC      = 4'd6
	} led_mode_e;

	// Bit 3 and bits 1..0 are spare
	typedef struct packed {
		led_mode_e  mode;
		logic       reserved_hi;
		logic       led_clear;
		logic [1:0] reserved;
	} control_t;

	typedef struct packed {
		led_mode_e        mode;
		logic [LED_W-1:0] led;
	} status_t;

	// Pattern FSM, one bit per state
	typedef enum logic [4:0] {
		ST_IDLE      = 5'b00001,
		ST_SELECT    = 5'b00010,
		ST_LOAD_REG  = 5'b00100,
		ST_LOAD_LEDS = 5'b01000,
		ST_WAIT      = 5'b10000
	} engine_state_e;

	// Handshake slot phases
	typedef enum logic [1:0] {
		SLOT_EMPTY = 2'd0,
		SLOT_HOLD  = 2'd1,
		SLOT_OFFER = 2'd2,
		SLOT_DRAIN = 2'd3
	} slot_state_e;

endpackage

//--- hs_stage.sv
//----------------------------------------------------------
// Four-phase req/ack register slot, generic payload
//----------------------------------------------------------

`timescale 1ns/1ps

module hs_stage
	import led_blinky_pkg::*;
#(
	parameter type payload_t = logic
) (
	input  logic     CLK_66,
	input  logic     RST,
	input  logic     in_req,
	output logic     in_ack,
	input  payload_t in_data,
	output logic     out_req,
	input  logic     out_ack,
	output payload_t out_data
);

	slot_state_e slot;

	// Handshake lines decode straight from the slot phase
	assign in_ack  = (slot == SLOT_HOLD);
	assign out_req = (slot == SLOT_OFFER);

	// Slot phase sequencing
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
			slot <= SLOT_EMPTY;
		else
		begin
			case (slot)
				// Take one item only when empty
				SLOT_EMPTY:
					if (in_req)
						slot <= SLOT_HOLD;
				// Sender has seen ack once req falls
				SLOT_HOLD:
					if (!in_req)
						slot <= SLOT_OFFER;
				SLOT_OFFER:
					if (out_ack)
						slot <= SLOT_DRAIN;
				// Wait for receiver to release ack
				SLOT_DRAIN:
					if (!out_ack)
						slot <= SLOT_EMPTY;
				default:
					slot <= SLOT_EMPTY;
			endcase
		end
	end

	// Captured item, held until the next accept
	always_ff @(posedge CLK_66)
	begin
		if (slot == SLOT_EMPTY && in_req)
			out_data <= in_data;
	end

	// Offered data must not move under req
	a_out_stable: assert property (@(posedge CLK_66) disable iff (!RST)
		out_req |=> (!out_req || $stable(out_data)));

	// Ack only rises with the output link at rest
	a_no_ack_full: assert property (@(posedge CLK_66) disable iff (!RST)
		$rose(in_ack) |-> $past(!out_req && !out_ack));

endmodule

//--- cmd_decoder.sv
//----------------------------------------------------------
// Host command decoder
// Control, timer, static, preset and seed registers
//----------------------------------------------------------

`timescale 1ns/1ps

module cmd_decoder
	import led_blinky_pkg::*;
(
	input  logic               CLK_66,
	input  logic               RST,
	input  logic               dec_req,
	output logic               dec_ack,
	input  cmd_t               dec_cmd,
	output control_t           control,
	output logic [TIMER_W-1:0] timer_value,
	output logic [LED_W-1:0]   static_value,
	output logic [LED_W-1:0]   preset_value,
	output logic               preset_load,
	output logic [LED_W-1:0]   seed,
	output logic               seed_load
);

	logic       apply;
	logic [7:0] timer_mid;
	logic [7:0] timer_high;

	// First cycle of a request, before ack goes up
	assign apply = dec_req && !dec_ack;

	// Low byte is not host writable
	assign timer_value = {timer_high, timer_mid, TIMER_RESET[7:0]};

	//----------------------------------------------------------
	// Handshake and register writes
	//----------------------------------------------------------
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			dec_ack      <= 1'b0;
			control      <= '0;
			static_value <= '0;
			timer_mid    <= TIMER_RESET[15:8];
			timer_high   <= TIMER_RESET[23:16];
			preset_load  <= 1'b0;
			seed_load    <= 1'b0;
		end
		else
		begin
			// Ack follows req by one cycle both ways
			dec_ack     <= dec_req;
			preset_load <= apply && (dec_cmd.op == OP_SHIFT_PRESET);
			seed_load   <= apply && (dec_cmd.op == OP_SEED);
			if (apply)
			begin
				case (dec_cmd.op)
					OP_CONTROL:
						control <= control_t'(dec_cmd.value);
					OP_STATIC:
						static_value <= dec_cmd.value[LED_W-1:0];
					OP_TIMER_MID:
						timer_mid <= dec_cmd.value;
					OP_TIMER_HIGH:
						timer_high <= dec_cmd.value;
					default:
						;
				endcase
			end
		end
	end

	// Load data, only meaningful with its pulse
	always_ff @(posedge CLK_66)
	begin
		if (apply && dec_cmd.op == OP_SHIFT_PRESET)
			preset_value <= dec_cmd.value[LED_W-1:0];
		if (apply && dec_cmd.op == OP_SEED)
			seed <= dec_cmd.value[LED_W-1:0];
	end

	// One load target per command
	a_one_load: assert property (@(posedge CLK_66) disable iff (!RST)
		!(preset_load && seed_load));

endmodule

//--- lfsr_source.sv
//----------------------------------------------------------
// Free-running 4-bit LFSR with seed load
//----------------------------------------------------------

`timescale 1ns/1ps

module lfsr_source
	import led_blinky_pkg::*;
(
	input  logic             CLK_66,
	input  logic             RST,
	input  logic [LED_W-1:0] seed,
	input  logic             seed_load,
	output logic [LED_W-1:0] random_value
);

	// Taps for x^4 + x^3 + 1
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
			random_value <= LFSR_RESET;
		else if (seed_load)
			// All-zero state would lock up
			random_value <= (seed == '0) ? LFSR_RESET : seed;
		else
			random_value <= {random_value[LED_W-2:0],
				random_value[3] ^ random_value[2]};
	end

	// Holds across seeds from the decoder too
	a_never_zero: assert property (@(posedge CLK_66) disable iff (!RST)
		random_value != '0);

endmodule

//--- pattern_engine.sv
//----------------------------------------------------------
// LED pattern FSM, pattern and dwell registers
// Status report on every LED update
//----------------------------------------------------------

`timescale 1ns/1ps

module pattern_engine
	import led_blinky_pkg::*;
(
	input  logic               CLK_66,
	input  logic               RST,
	input  control_t           control,
	input  logic [TIMER_W-1:0] timer_value,
	input  logic [LED_W-1:0]   static_value,
	input  logic [LED_W-1:0]   preset_value,
	input  logic               preset_load,
	input  logic [LED_W-1:0]   random_value,
	output logic [LED_W-1:0]   led,
	output logic               st_req,
	input  logic               st_ack,
	output status_t            st_status
);

	engine_state_e      state;
	engine_state_e      next;
	logic [LED_W-1:0]   pattern;
	logic [LED_W-1:0]   pattern_next;
	logic [TIMER_W-1:0] dwell;
	logic               link_idle;

	// Status link fully back to rest
	assign link_idle = !st_req && !st_ack;

	//----------------------------------------------------------
	// Next pattern per mode
	//----------------------------------------------------------
	always_comb
	begin
		case (control.mode)
			MODE_RANDOM:      pattern_next = random_value;
			MODE_SHIFT_LEFT:  pattern_next = {pattern[LED_W-2:0], pattern[LED_W-1]};
			MODE_SHIFT_RIGHT: pattern_next = {pattern[0], pattern[LED_W-1:1]};
			MODE_COUNT_UP:    pattern_next = pattern + 1'b1;
			MODE_COUNT_DOWN:  pattern_next = pattern - 1'b1;
			MODE_STATIC:      pattern_next = static_value;
			// Off and unused codes
			default:          pattern_next = '0;
		endcase
	end

	//----------------------------------------------------------
	// State transitions
	//----------------------------------------------------------
	always_comb
	begin
		next = state;
		case (state)
			// Start only with no report still in flight
			ST_IDLE:
				if (control.mode != MODE_OFF && link_idle)
					next = ST_SELECT;
			ST_SELECT:
				next = (control.mode == MODE_OFF) ? ST_IDLE : ST_LOAD_REG;
			ST_LOAD_REG:
				next = ST_LOAD_LEDS;
			ST_LOAD_LEDS:
				next = ST_WAIT;
			// Dwell done and report handshaken
			ST_WAIT:
				if (dwell == '0 && link_idle)
					next = ST_SELECT;
			default:
				next = ST_IDLE;
		endcase
		// Clear parks the FSM
		if (control.led_clear)
			next = ST_IDLE;
	end

	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
			state <= ST_IDLE;
		else
			state <= next;
	end

	//----------------------------------------------------------
	// Pattern, dwell, LEDs and status sender
	//----------------------------------------------------------
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			pattern <= '0;
			led     <= '0;
			dwell   <= '0;
			st_req  <= 1'b0;
		end
		else
		begin
			// Pattern register, preset beats the FSM
			if (control.led_clear)
				pattern <= '0;
			else if (preset_load)
				pattern <= preset_value;
			else if (state == ST_LOAD_REG)
				pattern <= pattern_next;

			// LED outputs
			if (control.led_clear)
				led <= '0;
			else if (state == ST_LOAD_LEDS)
				led <= pattern;

			// Dwell of timer_value + 1 cycles
			if (state == ST_LOAD_LEDS)
				dwell <= timer_value;
			else if (state == ST_WAIT && dwell != '0)
				dwell <= dwell - 1'b1;

			// Req up on entry to WAIT, down once acked
			if (state == ST_LOAD_LEDS && !control.led_clear)
				st_req <= 1'b1;
			else if (st_ack)
				st_req <= 1'b0;
		end
	end

	// Report payload, taken with the LED value
	always_ff @(posedge CLK_66)
	begin
		if (state == ST_LOAD_LEDS && !control.led_clear)
		begin
			st_status.mode <= control.mode;
			st_status.led  <= pattern;
		end
	end

	a_state_onehot: assert property (@(posedge CLK_66) disable iff (!RST)
		$onehot(state));

endmodule

//--- led_blinky_top.sv
//----------------------------------------------------------
// Top level of the command-driven LED peripheral
//----------------------------------------------------------

`timescale 1ns/1ps

module led_blinky
	import led_blinky_pkg::*;
(
	input  logic             CLK_66,
	input  logic             RST,
	input  logic             cmd_req,
	output logic             cmd_ack,
	input  cmd_t             cmd,
	output logic             status_req,
	input  logic             status_ack,
	output status_t          status,
	output logic [LED_W-1:0] led
);

	// Command stage to decoder
	logic dec_req;
	logic dec_ack;
	cmd_t dec_cmd;

	// Decoder to engine and LFSR
	control_t           control;
	logic [TIMER_W-1:0] timer_value;
	logic [LED_W-1:0]   static_value;
	logic [LED_W-1:0]   preset_value;
	logic               preset_load;
	logic [LED_W-1:0]   seed;
	logic               seed_load;
	logic [LED_W-1:0]   random_value;

	// Engine to status stage
	logic    st_req;
	logic    st_ack;
	status_t st_status;

	//----------------------------------------------------------
	// Command stage
	//----------------------------------------------------------
	hs_stage #(.payload_t(cmd_t)) u_cmd_stage (
		.CLK_66   (CLK_66),
		.RST      (RST),
		.in_req   (cmd_req),
		.in_ack   (cmd_ack),
		.in_data  (cmd),
		.out_req  (dec_req),
		.out_ack  (dec_ack),
		.out_data (dec_cmd)
	);

	cmd_decoder u_cmd_decoder (
		.CLK_66       (CLK_66),
		.RST          (RST),
		.dec_req      (dec_req),
		.dec_ack      (dec_ack),
		.dec_cmd      (dec_cmd),
		.control      (control),
		.timer_value  (timer_value),
		.static_value (static_value),
		.preset_value (preset_value),
		.preset_load  (preset_load),
		.seed         (seed),
		.seed_load    (seed_load)
	);

	//----------------------------------------------------------
	// Pattern stage
	//----------------------------------------------------------
	lfsr_source u_lfsr_source (
		.CLK_66       (CLK_66),
		.RST          (RST),
		.seed         (seed),
		.seed_load    (seed_load),
		.random_value (random_value)
	);

	pattern_engine u_pattern_engine (
		.CLK_66       (CLK_66),
		.RST          (RST),
		.control      (control),
		.timer_value  (timer_value),
		.static_value (static_value),
		.preset_value (preset_value),
		.preset_load  (preset_load),
		.random_value (random_value),
		.led          (led),
		.st_req       (st_req),
		.st_ack       (st_ack),
		.st_status    (st_status)
	);

	//----------------------------------------------------------
	// Status stage
	//----------------------------------------------------------
	hs_stage #(.payload_t(status_t)) u_status_stage (
		.CLK_66   (CLK_66),
		.RST      (RST),
		.in_req   (st_req),
		.in_ack   (st_ack),
		.in_data  (st_status),
		.out_req  (status_req),
		.out_ack  (status_ack),
		.out_data (status)
	);

endmodule

//--- led_checker.sv
//----------------------------------------------------------
// LED report checker, predicts reports from the mode rules
//----------------------------------------------------------

`timescale 1ns/1ps

module led_checker
	import led_blinky_pkg::*;
(
	input  logic             CLK_66,
	input  logic             RST,
	input  logic             cmd_ack,
	input  cmd_t             cmd,
	input  logic             status_req,
	input  status_t          status,
	input  logic [LED_W-1:0] led,
	input  logic [8*12-1:0]  test_name,
	input  logic             active,
	input  logic             quiet,
	input  logic [LED_W-1:0] first_led,
	input  logic [3:0]       report_mode,
	output int               report_count,
	output int               error_count
);

	logic             req_seen;
	logic             ack_seen;
	logic [LED_W-1:0] expected;
	int               clear_wait;

	// Pattern step between two reports
	function automatic logic [LED_W-1:0] next_expected(input logic [3:0] mode,
		input logic [LED_W-1:0] prev);
		case (mode)
			MODE_SHIFT_LEFT:  return {prev[2:0], prev[3]};
			MODE_SHIFT_RIGHT: return {prev[0], prev[3:1]};
			MODE_COUNT_UP:    return prev + 4'd1;
			MODE_COUNT_DOWN:  return prev - 4'd1;
			// Static and unused codes repeat
			default:          return prev;
		endcase
	endfunction

	// Compare one report, returns number of wrong fields
	function automatic int report_errors(input logic [LED_W-1:0] want);
		int errs;
		errs = 0;
		// Random only has to avoid the all-off value
		if (report_mode == MODE_RANDOM)
		begin
			if (status.led == '0)
			begin
				$display("error: %s random report shows all LEDs off", test_name);
				errs++;
			end
		end
		else if (status.led != want)
		begin
			$display("mismatch %s led expected %h actual %h", test_name, want, status.led);
			errs++;
		end
		if (status.mode != report_mode)
		begin
			$display("mismatch %s mode expected %h actual %h", test_name, report_mode,
				status.mode);
			errs++;
		end
		// LED port still shows the reported value
		if (led != status.led)
		begin
			$display("mismatch %s led port expected %h actual %h", test_name, status.led, led);
			errs++;
		end
		return errs;
	endfunction

	always @(posedge CLK_66 or negedge RST)
	begin : watch
		int               errs;
		logic [LED_W-1:0] want;
		if (!RST)
		begin
			req_seen     <= 1'b0;
			ack_seen     <= 1'b0;
			expected     <= '0;
			clear_wait   <= 0;
			report_count <= 0;
			error_count  <= 0;
		end
		else
		begin
			errs = 0;
			req_seen <= status_req;
			ack_seen <= cmd_ack;
			// New report on the rising edge of status_req
			if (status_req && !req_seen)
			begin
				if (quiet)
				begin
					$display("error: %s status report arrived while reports were stopped",
						test_name);
					errs++;
				end
				else if (active)
				begin
					want = (report_count == 0) ? first_led : next_expected(report_mode, expected);
					errs += report_errors(want);
					expected     <= want;
					report_count <= report_count + 1;
				end
			end
			if (!active)
				report_count <= 0;
			// Clear command accepted, LEDs dark within 5 cycles
			if (cmd_ack && !ack_seen && cmd.op == OP_CONTROL && cmd.value[2])
				clear_wait <= 5;
			else if (clear_wait != 0)
			begin
				clear_wait <= clear_wait - 1;
				if (clear_wait == 1 && led != '0)
				begin
					$display("error: %s LEDs still lit 5 cycles after the clear command",
						test_name);
					errs++;
				end
			end
			error_count <= error_count + errs;
		end
	end

endmodule

//--- tb_led_blinky.sv
//----------------------------------------------------------
// Testbench top, clock, reset, command table
// Host side of both links and watchdog
//----------------------------------------------------------

`timescale 1ns/1ps

module tb_led_blinky
	import led_blinky_pkg::*;
();

	// Dwell timer with both host bytes at 0
	localparam int DWELL_TIMER  = int'(TIMER_RESET[7:0]);
	localparam int QUIET_CYCLES = 100;
	localparam int CMD_CYCLES   = 10;

	// One table row, commands applied low index first
	typedef struct packed {
		logic [8*12-1:0]  name;
		cmd_t [1:0]       cmds;
		logic [1:0]       n_cmds;
		logic [3:0]       n_reports;
		logic [LED_W-1:0] first_led;
		logic [3:0]       report_mode;
		logic             slow_ack;
	} test_row_t;

	logic             CLK_66 = 1'b0;
	logic             RST;
	logic             cmd_req;
	logic             cmd_ack;
	cmd_t             cmd;
	logic             status_req;
	logic             status_ack;
	status_t          status;
	logic [LED_W-1:0] led;

	// Checker controls
	logic [8*12-1:0]  test_name;
	logic             active;
	logic             quiet;
	logic [LED_W-1:0] first_led;
	logic [3:0]       report_mode;
	logic             slow_ack;
	int               report_count;
	int               error_count;
	int               tb_errors;
	int               limit_cycles = 0;
	test_row_t        table_q[$];

	led_blinky u_led_blinky (
		.CLK_66     (CLK_66),
		.RST        (RST),
		.cmd_req    (cmd_req),
		.cmd_ack    (cmd_ack),
		.cmd        (cmd),
		.status_req (status_req),
		.status_ack (status_ack),
		.status     (status),
		.led        (led)
	);

	led_checker u_led_checker (
		.CLK_66       (CLK_66),
		.RST          (RST),
		.cmd_ack      (cmd_ack),
		.cmd          (cmd),
		.status_req   (status_req),
		.status       (status),
		.led          (led),
		.test_name    (test_name),
		.active       (active),
		.quiet        (quiet),
		.first_led    (first_led),
		.report_mode  (report_mode),
		.report_count (report_count),
		.error_count  (error_count)
	);

	always #5 CLK_66 = ~CLK_66;

	function automatic cmd_t make_cmd(input cmd_op_e op, input logic [7:0] value);
		cmd_t c;
		c.op    = op;
		c.value = value;
		return c;
	endfunction

	function automatic void add_row(input logic [8*12-1:0] name, input cmd_t c0,
		input cmd_t c1, input logic [1:0] n_cmds, input logic [3:0] n_reports,
		input logic [3:0] first, input logic [3:0] mode, input logic slow);
		test_row_t r;
		r.name        = name;
		r.cmds[0]     = c0;
		r.cmds[1]     = c1;
		r.n_cmds      = n_cmds;
		r.n_reports   = n_reports;
		r.first_led   = first;
		r.report_mode = mode;
		r.slow_ack    = slow;
		table_q.push_back(r);
	endfunction

	// Worst-case length of one row in cycles
	function automatic int row_cycles(input test_row_t r);
		int cmds;
		int reports;
		cmds    = int'(r.n_cmds) + 3;
		reports = int'(r.n_reports);
		return cmds * CMD_CYCLES + (DWELL_TIMER + 20) + QUIET_CYCLES
			+ reports * (DWELL_TIMER + 20) + ((reports == 0) ? QUIET_CYCLES : 0);
	endfunction

	// Four-phase host write on the command link
	task automatic send_cmd(input cmd_t c);
		@(posedge CLK_66);
		cmd     <= c;
		cmd_req <= 1'b1;
		@(posedge CLK_66);
		while (!cmd_ack)
			@(posedge CLK_66);
		cmd_req <= 1'b0;
		@(posedge CLK_66);
		while (cmd_ack)
			@(posedge CLK_66);
	endtask

	task automatic run_row(input test_row_t row);
		// Stop the previous pattern, shortest dwell
		active   <= 1'b0;
		quiet    <= 1'b0;
		slow_ack <= row.slow_ack;
		send_cmd(make_cmd(OP_CONTROL, 8'h00));
		send_cmd(make_cmd(OP_TIMER_MID, 8'h00));
		send_cmd(make_cmd(OP_TIMER_HIGH, 8'h00));
		// Report still in flight may land here
		repeat (QUIET_CYCLES)
			@(posedge CLK_66);
		test_name   <= row.name;
		first_led   <= row.first_led;
		report_mode <= row.report_mode;
		// Longer than one dwell, a running engine would report in here
		quiet       <= 1'b1;
		repeat (DWELL_TIMER + 20)
			@(posedge CLK_66);
		quiet  <= (row.n_reports == 4'd0);
		active <= (row.n_reports != 4'd0);
		send_cmd(row.cmds[0]);
		if (row.n_cmds > 2'd1)
			send_cmd(row.cmds[1]);
		if (row.n_reports == 4'd0)
			repeat (QUIET_CYCLES)
				@(posedge CLK_66);
		else
			while (report_count < int'(row.n_reports))
				@(posedge CLK_66);
		active <= 1'b0;
		quiet  <= 1'b0;
	endtask

	//----------------------------------------------------------
	// Status link receiver, optional random ack delay
	//----------------------------------------------------------
	initial
	begin : status_host
		int delay;
		status_ack = 1'b0;
		forever
		begin
			@(posedge CLK_66);
			if (status_req && !status_ack)
			begin
				delay = slow_ack ? int'($urandom % 4) : 0;
				repeat (delay)
					@(posedge CLK_66);
				status_ack <= 1'b1;
				@(posedge CLK_66);
				while (status_req)
					@(posedge CLK_66);
				status_ack <= 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles)
			@(posedge CLK_66);
		$display("timeout: status reports stopped arriving");
		$display("Simulation failed");
		$finish;
	end

	initial
	begin : main
		RST         = 1'b0;
		cmd_req     = 1'b0;
		cmd         = '0;
		test_name   = '0;
		active      = 1'b0;
		quiet       = 1'b0;
		first_led   = '0;
		report_mode = '0;
		slow_ack    = 1'b0;
		tb_errors   = 0;
		void'($urandom(32'hdc5b71da));

		// Name, commands, reports, first LED value, mode, slow ack
		add_row("static      ", make_cmd(OP_STATIC, 8'h09), make_cmd(OP_CONTROL, 8'h60),
			2'd2, 4'd3, 4'h9, MODE_STATIC, 1'b0);
		add_row("shift left  ", make_cmd(OP_SHIFT_PRESET, 8'h01), make_cmd(OP_CONTROL, 8'h20),
			2'd2, 4'd4, 4'h2, MODE_SHIFT_LEFT, 1'b0);
		add_row("shift right ", make_cmd(OP_SHIFT_PRESET, 8'h08), make_cmd(OP_CONTROL, 8'h30),
			2'd2, 4'd4, 4'h4, MODE_SHIFT_RIGHT, 1'b0);
		add_row("count up    ", make_cmd(OP_SHIFT_PRESET, 8'h0e), make_cmd(OP_CONTROL, 8'h40),
			2'd2, 4'd3, 4'hf, MODE_COUNT_UP, 1'b0);
		add_row("count down  ", make_cmd(OP_SHIFT_PRESET, 8'h01), make_cmd(OP_CONTROL, 8'h50),
			2'd2, 4'd3, 4'h0, MODE_COUNT_DOWN, 1'b0);
		// Clear with a live mode, LEDs go dark and stay quiet
		add_row("led clear   ", make_cmd(OP_CONTROL, 8'h44), make_cmd(OP_CONTROL, 8'h44),
			2'd1, 4'd0, 4'h0, MODE_COUNT_UP, 1'b0);
		add_row("random      ", make_cmd(OP_SEED, 8'h00), make_cmd(OP_CONTROL, 8'h10),
			2'd2, 4'd4, 4'h0, MODE_RANDOM, 1'b0);
		add_row("unused mode ", make_cmd(OP_CONTROL, 8'h90), make_cmd(OP_CONTROL, 8'h90),
			2'd1, 4'd2, 4'h0, 4'h9, 1'b0);
		add_row("backpressure", make_cmd(OP_SHIFT_PRESET, 8'h03), make_cmd(OP_CONTROL, 8'h40),
			2'd2, 4'd5, 4'h4, MODE_COUNT_UP, 1'b1);

		limit_cycles = 20;
		foreach (table_q[i])
			limit_cycles += row_cycles(table_q[i]);

		repeat (5)
			@(posedge CLK_66);
		RST <= 1'b1;
		@(posedge CLK_66);
		if (led !== '0 || cmd_ack !== 1'b0 || status_req !== 1'b0)
		begin
			$display("error: outputs not idle after reset");
			tb_errors++;
		end

		foreach (table_q[i])
			run_row(table_q[i]);

		repeat (10)
			@(posedge CLK_66);
		$display("errors: checker %0d testbench %0d", error_count, tb_errors);
		if (error_count == 0 && tb_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- led_blinky.f
led_blinky_pkg.sv
hs_stage.sv
cmd_decoder.sv
lfsr_source.sv
pattern_engine.sv
led_blinky_top.sv
led_checker.sv
tb_led_blinky.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LED peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f led_blinky.f \
	--top-module tb_led_blinky -o tb_led_blinky

./obj_dir/tb_led_blinky 2>&1 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi
